//--- hw/smac_pkg.sv
// Shared types and constants of the sub-MAC.
// Operand words carry 4x int8, 2x int16 or 1x int32 lanes, selected at run time.
// Lane k of an operand word maps to lane k of the 64-bit result word.
// Precision code 3 is reserved and every block treats it as INT32.

package smac_pkg;

  ////////////////////////////////////////////////////////////////////
  // slice geometry and latency
  ////////////////////////////////////////////////////////////////////
  localparam int SLICE_W = 17;  // signed operand width of one slice
  localparam int CASC_W  = 48;  // product and cascade width
  localparam int MUL_LAT = 3;   // ce edge to packed product, in clock edges

  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,          // four 8-bit lanes
    PREC_INT16 = 2'd1,          // two 16-bit lanes
    PREC_INT32 = 2'd2           // one 32-bit lane, 3 behaves the same
  } prec_e;

  // signed element types, so a lane select keeps its sign
  typedef logic signed [7:0]  s8_t;
  typedef logic signed [15:0] s16_t;
  typedef logic signed [31:0] s32_t;
  typedef logic signed [63:0] s64_t;

  ////////////////////////////////////////////////////////////////////
  // lane views of operand and result words
  ////////////////////////////////////////////////////////////////////
  typedef union packed {
    s8_t  [3:0] b8;             // int8 lanes, lane 0 in bits 7:0
    s16_t [1:0] h16;            // int16 lanes, also the int32 halves
    s32_t       w32;            // whole int32 word
  } simd_word_u;

  typedef union packed {
    s16_t [3:0] l16;            // int8 mode accumulators
    s32_t [1:0] l32;            // int16 mode accumulators
    s64_t       l64;            // int32 mode accumulator
  } acc_word_u;

endpackage

//--- hw/dsp_mul_slice.sv
// Behavioural model of one DSP multiplier slice, 17x17 signed.
// Two register stages, both advancing only while ce_i is high, so the caller
// keeps ce_i up for two edges to push one product through.
// pcout_o adds pcin_i unshifted; any alignment of the cascade is done outside.
// reset_i acts as the synchronous clear of all slice registers.

module dsp_mul_slice (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic                                ce_i,
  input  logic signed [smac_pkg::SLICE_W-1:0] a_i,
  input  logic signed [smac_pkg::SLICE_W-1:0] b_i,
  input  logic signed [smac_pkg::CASC_W-1:0]  pcin_i,
  output logic signed [smac_pkg::CASC_W-1:0]  p_o,
  output logic signed [smac_pkg::CASC_W-1:0]  pcout_o
);

  logic signed [smac_pkg::SLICE_W-1:0] a_q;     // stage one operand regs
  logic signed [smac_pkg::SLICE_W-1:0] b_q;
  logic signed [smac_pkg::CASC_W-1:0]  m_q;     // stage two product reg

  ////////////////////////////////////////////////////////////////////
  // pipeline
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin                          // sclr
      a_q <= '0;
      b_q <= '0;
      m_q <= '0;
    end else if (ce_i) begin
      a_q <= a_i;
      b_q <= b_i;
      m_q <= a_q * b_q;                         // sign extended to 48 before multiply
    end
  end

  // post adder, generic cascade sum
  assign p_o     = m_q;
  assign pcout_o = m_q + pcin_i;                // combinational through the chain

endmodule

//--- hw/smul.sv
// Lane-splitting signed multiplier array built from four slices.
// INT8 uses all four slices, INT16 slices 0 and 1, INT32 all four with the
// partial products summed through the cascade.
// mode_i and the operands must stay stable from the ce_i pulse until the
// product is out, MUL_LAT edges after the ce edge.
// prod_o holds the last product until the next one is registered.

module smul (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            ce_i,
  input  smac_pkg::prec_e mode_i,
  input  logic [31:0]     data_i,
  input  logic [31:0]     weight_i,
  output logic [63:0]     prod_o
);

  smac_pkg::simd_word_u data_w;                 // operand lane views
  smac_pkg::simd_word_u wght_w;
  smac_pkg::acc_word_u  prod_d;                 // packed lanes before the out reg
  smac_pkg::acc_word_u  prod_q;
  logic       is_int8;
  logic       is_int16;
  logic       is_int32;
  logic [3:0] lane_en;
  logic [3:0] slice_ce;
  logic       v1_q;                             // operands sit in stage one
  logic       v2_q;                             // product sits in stage two
  logic signed [smac_pkg::CASC_W-1:0] pcin_s  [4];
  logic signed [smac_pkg::CASC_W-1:0] p_s     [4];
  logic signed [smac_pkg::CASC_W-1:0] pcout_s [4];

  assign data_w   = data_i;
  assign wght_w   = weight_i;
  assign is_int8  = (mode_i == smac_pkg::PREC_INT8);
  assign is_int16 = (mode_i == smac_pkg::PREC_INT16);
  assign is_int32 = !is_int8 && !is_int16;      // reserved code lands here too

  ////////////////////////////////////////////////////////////////////
  // enable network
  ////////////////////////////////////////////////////////////////////
  assign lane_en  = is_int16 ? 4'b0011 : 4'b1111;
  assign slice_ce = lane_en & {4{ce_i | v1_q}}; // held for two edges per product

  always_ff @(posedge clk) begin
    if (reset_i) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      v1_q <= ce_i;
      v2_q <= v1_q;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // operand steering and slices
  ////////////////////////////////////////////////////////////////////
  for (genvar k = 0; k < 4; k++) begin : g_lane
    // INT32 partial product of slice k uses data half k%2 and weight half k/2
    localparam int AH = k % 2;
    localparam int BH = k / 2;
    logic signed [smac_pkg::SLICE_W-1:0] a_k;
    logic signed [smac_pkg::SLICE_W-1:0] b_k;

    always_comb begin
      if (is_int8) begin
        a_k = data_w.b8[k];                     // sign extended byte
        b_k = wght_w.b8[k];
      end else if (is_int16) begin
        a_k = data_w.h16[AH];                   // slices 2,3 are frozen anyway
        b_k = wght_w.h16[AH];
      end else begin
        if (AH == 1) a_k = data_w.h16[1];       // high half signed
        else         a_k = {1'b0, data_w.h16[0]}; // low half unsigned
        if (BH == 1) b_k = wght_w.h16[1];
        else         b_k = {1'b0, wght_w.h16[0]};
      end
    end

    dsp_mul_slice u_slice (
      .clk     (clk),
      .reset_i (reset_i),
      .ce_i    (slice_ce[k]),
      .a_i     (a_k),
      .b_i     (b_k),
      .pcin_i  (pcin_s[k]),
      .p_o     (p_s[k]),
      .pcout_o (pcout_s[k])
    );
  end

  // cascade, only live in INT32
  always_comb begin
    pcin_s[0] = '0;
    pcin_s[1] = '0;
    pcin_s[2] = '0;
    pcin_s[3] = '0;
    if (is_int32) begin
      pcin_s[1] = pcout_s[0] >>> 16;            // lo*lo drops its 16 output bits
      pcin_s[2] = pcout_s[1];                   // hi*lo and lo*hi share weight 2^16
      pcin_s[3] = pcout_s[2] >>> 16;            // aligned to weight 2^32
    end
  end

  ////////////////////////////////////////////////////////////////////
  // output packing, each lane wraps to its width
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    prod_d = '0;
    if (is_int8) begin
      for (int k = 0; k < 4; k++) begin
        prod_d.l16[k] = p_s[k][15:0];
      end
    end else if (is_int16) begin
      for (int k = 0; k < 2; k++) begin
        prod_d.l32[k] = p_s[k][31:0];
      end
    end else begin
      prod_d.l64 = {pcout_s[3][31:0], pcout_s[2][15:0], p_s[0][15:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (v2_q) prod_q <= prod_d;                 // third edge after ce
  end

  assign prod_o = prod_q;

endmodule

//--- hw/mac_accum.sv
// Lane-wise accumulator over the 64-bit result word.
// Lanes are 16 bits in INT8, 32 bits in INT16 and 64 bits in INT32 mode.
// Every lane wraps on its own, no carry crosses a lane boundary.
// A load replaces the whole word with the product.

module mac_accum (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            en_i,
  input  logic            load_i,
  input  smac_pkg::prec_e mode_i,
  input  logic [63:0]     prod_i,
  output logic [63:0]     acc_o
);

  smac_pkg::acc_word_u prod_w;
  smac_pkg::acc_word_u acc_q;
  smac_pkg::acc_word_u sum_d;                   // acc + prod per lane

  assign prod_w = prod_i;

  ////////////////////////////////////////////////////////////////////
  // lane adders
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    sum_d = acc_q;
    case (mode_i)
      smac_pkg::PREC_INT8: begin
        for (int k = 0; k < 4; k++) begin
          sum_d.l16[k] = acc_q.l16[k] + prod_w.l16[k]; // 16-bit wrap
        end
      end
      smac_pkg::PREC_INT16: begin
        for (int k = 0; k < 2; k++) begin
          sum_d.l32[k] = acc_q.l32[k] + prod_w.l32[k]; // 32-bit wrap
        end
      end
      default: begin
        sum_d.l64 = acc_q.l64 + prod_w.l64;     // int32 and reserved code
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= load_i ? prod_w : sum_d;         // clear flag reloads from product
    end
  end

  assign acc_o = acc_q;

endmodule

//--- hw/mac_ctrl.sv
// Four-phase req/ack sequencer, one transaction in flight at a time.
// With N the edge that sees req_i high in IDLE: multiply enable is sampled
// at N+1, the accumulate strobe at N+4, and ack_o is high after N+5.
// ack_o drops after the first edge that sees req_i low once waiting.
// Request inputs must stay stable while req_i is high.

module mac_ctrl (
  input  logic clk,
  input  logic reset_i,
  input  logic req_i,
  input  logic clear_i,
  output logic ack_o,
  output logic mul_ce_o,
  output logic acc_en_o,
  output logic acc_load_o
);

  typedef enum logic [2:0] {
    IDLE,                                       // ready for a request
    ISSUE,                                      // multiply enable
    WAIT,                                       // product in flight
    ACCUM,                                      // accumulate strobe
    ACK,                                        // result settles, ack goes up
    RELEASE                                     // ack high, wait for req low
  } state_e;

  state_e     state_q;
  logic [1:0] cnt_q;                            // edges left until product valid
  logic       clear_q;                          // clear flag of this transaction
  logic       ack_q;

  ////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      clear_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q <= ISSUE;
            clear_q <= clear_i;
            cnt_q   <= 2'(smac_pkg::MUL_LAT);
          end
        end
        ISSUE: begin
          state_q <= WAIT;
          cnt_q   <= cnt_q - 2'd1;
        end
        WAIT: begin
          cnt_q <= cnt_q - 2'd1;
          if (cnt_q == 2'd1) state_q <= ACCUM;  // product out after this edge
        end
        ACCUM:   state_q <= ACK;
        ACK: begin
          ack_q   <= 1'b1;
          state_q <= RELEASE;
        end
        RELEASE: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign mul_ce_o   = (state_q == ISSUE);
  assign acc_en_o   = (state_q == ACCUM);
  assign acc_load_o = (state_q == ACCUM) && clear_q;
  assign ack_o      = ack_q;

endmodule

//--- hw/smac_top.sv
// Multi-precision signed MAC, one operand pair per req/ack handshake.
// mode_i selects 4x INT8, 2x INT16 or 1x INT32 lanes for each transaction.
// clear_i reloads the accumulator from the product instead of adding.
// acc_o is valid while ack_o is high and holds between transactions.
// All request inputs are held stable while req_i is high.

module smac_top (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            req_i,
  input  smac_pkg::prec_e mode_i,
  input  logic            clear_i,
  input  logic [31:0]     data_i,
  input  logic [31:0]     weight_i,
  output logic            ack_o,
  output logic [63:0]     acc_o
);

  logic        mul_ce;                          // one cycle multiply enable
  logic        acc_en;                          // one cycle accumulate strobe
  logic        acc_load;
  logic [63:0] prod;                            // packed lane products

  ////////////////////////////////////////////////////////////////////
  // sequencer, multiplier array, accumulator
  ////////////////////////////////////////////////////////////////////
  mac_ctrl u_ctrl (
    .clk        (clk),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .clear_i    (clear_i),
    .ack_o      (ack_o),
    .mul_ce_o   (mul_ce),
    .acc_en_o   (acc_en),
    .acc_load_o (acc_load)
  );

  smul u_mul (
    .clk      (clk),
    .reset_i  (reset_i),
    .ce_i     (mul_ce),
    .mode_i   (mode_i),
    .data_i   (data_i),
    .weight_i (weight_i),
    .prod_o   (prod)
  );

  mac_accum u_acc (
    .clk     (clk),
    .reset_i (reset_i),
    .en_i    (acc_en),
    .load_i  (acc_load),
    .mode_i  (mode_i),
    .prod_i  (prod),
    .acc_o   (acc_o)
  );

endmodule

//--- tb/tb_smac_top.sv
// Testbench of smac_top, driven through the four-phase req/ack handshake.
// Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge.
// Expected accumulator values come from a lane-wise reference model.
// One transaction in flight at a time, random operands from a fixed seed.

module tb_smac_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYC   = 5;
  localparam int MAX_TXN     = 60;
  localparam int TIMEOUT_CYC = MAX_TXN * 12 + RESET_CYC;  // 12 cycles per txn at most

  logic                clk = 1'b0;
  logic                reset_i;
  logic                req_i;
  smac_pkg::prec_e     mode_i;
  logic                clear_i;
  logic [31:0]         data_i;
  logic [31:0]         weight_i;
  logic                ack_o;
  logic [63:0]         acc_o;

  smac_pkg::acc_word_u model_acc;               // expected result after current txn
  integer              seed = 75;
  int                  cyc_cnt = 0;
  int                  n_txn = 0;               // transactions issued
  int                  n_checked = 0;           // ack rises compared
  logic                ack_prev = 1'b0;
  logic [31:0]         dir_d [5] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000,
                                     32'h7FFF_FFFF, 32'hFFFF_FFFF};
  logic [31:0]         dir_w [5] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                                     32'h8000_0000, 32'h0001_0000};

  always #4 clk = ~clk;                         // 8 ns period

  smac_top u_dut (
    .clk      (clk),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .mode_i   (mode_i),
    .clear_i  (clear_i),
    .data_i   (data_i),
    .weight_i (weight_i),
    .ack_o    (ack_o),
    .acc_o    (acc_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////////////////////////
  function automatic smac_pkg::acc_word_u ref_acc(input smac_pkg::prec_e mode,
      input logic clr, input smac_pkg::acc_word_u prev,
      input smac_pkg::simd_word_u d, input smac_pkg::simd_word_u w);
    smac_pkg::acc_word_u prod;
    smac_pkg::acc_word_u sum;
    logic signed [63:0]  da;
    logic signed [63:0]  wa;
    logic signed [63:0]  full;
    prod = '0;
    sum  = prev;
    case (mode)
      smac_pkg::PREC_INT8: begin
        for (int k = 0; k < 4; k++) begin
          da = d.b8[k];                         // sign extends
          wa = w.b8[k];
          full = da * wa;
          prod.l16[k] = full[15:0];
          sum.l16[k]  = prev.l16[k] + prod.l16[k]; // 16-bit lane wrap
        end
      end
      smac_pkg::PREC_INT16: begin
        for (int k = 0; k < 2; k++) begin
          da = d.h16[k];
          wa = w.h16[k];
          full = da * wa;
          prod.l32[k] = full[31:0];
          sum.l32[k]  = prev.l32[k] + prod.l32[k];
        end
      end
      default: begin                            // int32, reserved code too
        da = d.w32;
        wa = w.w32;
        prod.l64 = da * wa;                     // exact, fits in 64 bits
        sum.l64  = prev.l64 + prod.l64;
      end
    endcase
    return clr ? prod : sum;
  endfunction

  task automatic report_mismatch(input string what);
    $display("CHECK FAILED at %0d ns: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic check_acc(input smac_pkg::acc_word_u got, input smac_pkg::acc_word_u exp,
                           input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s, acc_o %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_ack(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s, ack_o %b expected %b", what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // handshake driver
  //////////////////////////////////////////////////////////////////////
  task automatic do_txn(input smac_pkg::prec_e mode, input logic clr,
                        input logic [31:0] d, input logic [31:0] w, input int stall);
    model_acc = ref_acc(mode, clr, model_acc, d, w);
    @(posedge clk);
    #1;
    mode_i   = mode;
    clear_i  = clr;
    data_i   = d;
    weight_i = w;
    req_i    = 1'b1;                            // sampled at edge N
    for (int i = 0; i < 6; i++) begin           // before edge N, then after N up to N+4
      @(negedge clk);
      check_ack(ack_o, 1'b0, "ack_o rose before edge N+5");
    end
    @(negedge clk);
    check_ack(ack_o, 1'b1, "ack_o not high after edge N+5");
    repeat (stall) begin                        // requester stalls with req_i high
      @(negedge clk);
      check_ack(ack_o, 1'b1, "ack_o dropped during stall");
      check_acc(acc_o, model_acc, "acc_o moved during stall");
    end
    @(posedge clk);
    #1;
    req_i = 1'b0;
    @(negedge clk);
    check_ack(ack_o, 1'b1, "ack_o fell before req_i was sampled low");
    @(negedge clk);
    check_ack(ack_o, 1'b0, "ack_o still high after req_i dropped");
    n_txn++;
  endtask

  // compare at every ack rise
  always @(negedge clk) begin
    if (!reset_i && ack_o && !ack_prev) begin
      check_acc(acc_o, model_acc, "acc_o at ack rise");
      n_checked++;
    end
    ack_prev = ack_o;
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > TIMEOUT_CYC) begin
      $display("ERRORS FOUND");
      $fatal(1, "timeout: handshake never completed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    reset_i   = 1'b1;
    req_i     = 1'b0;
    mode_i    = smac_pkg::PREC_INT8;
    clear_i   = 1'b0;
    data_i    = '0;
    weight_i  = '0;
    model_acc = '0;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    check_ack(ack_o, 1'b0, "ack_o high after reset");
    check_acc(acc_o, '0, "acc_o not zero after reset");

    for (int i = 0; i < 17; i++) begin          // int8, 15 accumulating then a reload
      do_txn(smac_pkg::PREC_INT8, (i == 0) || (i == 16), $random(seed), $random(seed), i % 3);
    end
    for (int i = 0; i < 10; i++) begin
      do_txn(smac_pkg::PREC_INT16, (i == 0) || (i == 6), $random(seed), $random(seed), i % 2);
    end
    for (int i = 0; i < 5; i++) begin           // int32 sign corners through the cascade
      do_txn(smac_pkg::PREC_INT32, i == 0, dir_d[i], dir_w[i], 0);
    end
    for (int i = 0; i < 6; i++) begin
      do_txn(smac_pkg::PREC_INT32, i == 3, $random(seed), $random(seed), i % 3);
    end

    @(negedge clk);
    if (n_checked != n_txn) begin
      $display("ERRORS FOUND");
      $fatal(1, "only %0d of %0d results were compared", n_checked, n_txn);
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- build.f
hw/smac_pkg.sv
hw/dsp_mul_slice.sv
hw/smul.sv
hw/mac_accum.sv
hw/mac_ctrl.sv
hw/smac_top.sv
tb/tb_smac_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is the simulator's, nonzero when the testbench stops with $fatal.

cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --top-module tb_smac_top \
       -f build.f -o sim_smac \
  && ./obj_dir/sim_smac \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
